/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int XLEN           = 32;
  localparam int REG_ADDRWIDTH  = 5;
  localparam int CSR_ADDRWIDTH  = 12;
  localparam int SHAMT_WIDTH    = 5;
  localparam int ALUOP_LEN      = 4;
  localparam int BROP_LEN       = 4;
  localparam int PCOP_LEN       = 2;
  localparam int MEMOP_LEN      = 4;
  localparam int CSROP_LEN      = 2;
  localparam int TRAP_CAUSE_LEN = 4;

  localparam logic [XLEN-1:0] INST_NOP    = 32'h0000_0013; // addi x0,x0,0
  localparam logic [1:0]      CSR_RO_BITS = 2'b11;         // csr_addr[11:10] of read-only CSRs

  typedef enum logic [ALUOP_LEN-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10  // LUI
  } alu_op_e;

  typedef enum logic [BROP_LEN-1:0] {
    BR_NONE = 4'd0,
    BR_BEQ  = 4'd1,
    BR_BNE  = 4'd2,
    BR_BLT  = 4'd3,
    BR_BGE  = 4'd4,
    BR_BLTU = 4'd5,
    BR_BGEU = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } br_op_e;

  typedef enum logic [PCOP_LEN-1:0] {
    PCOP_NONE = 2'd0,
    PCOP_JUMP = 2'd1
  } pc_op_e;

  typedef enum logic [MEMOP_LEN-1:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LH   = 4'd2,
    MEMOP_LW   = 4'd3,
    MEMOP_LBU  = 4'd4,
    MEMOP_LHU  = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } mem_op_e;

  typedef enum logic [CSROP_LEN-1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

  typedef enum logic [TRAP_CAUSE_LEN-1:0] {
    TRAP_INST_MISALIGNED = 4'd0,
    TRAP_ILLEGAL_INST    = 4'd2
  } trap_cause_e;

  typedef struct packed {
    logic              valid;
    trap_cause_e       cause;
    logic [XLEN-1:0]   tval;
  } trap_t;

  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [XLEN-1:0]          inst;
    logic [XLEN-1:0]          imm;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    logic [REG_ADDRWIDTH-1:0] rs1_idx;
    logic [REG_ADDRWIDTH-1:0] rd_idx;
    alu_op_e                  alu_op;
    logic                     use_imm;
    logic                     use_pc;
    br_op_e                   br_op;
    mem_op_e                  mem_op;
    csr_op_e                  csr_op;
    logic [CSR_ADDRWIDTH-1:0] csr_addr;
    trap_t                    trap;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_data;
    pc_op_e          pc_op;
    logic [XLEN-1:0] redirect_pc;
    logic            misaligned;
  } alu_res_t;

  typedef struct packed {
    logic [XLEN-1:0] wdata;
    logic            wvalid;
    logic            illegal;
  } csr_res_t;

  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [XLEN-1:0]          inst;
    logic [XLEN-1:0]          imm;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    logic [REG_ADDRWIDTH-1:0] rd_idx;
    logic [XLEN-1:0]          alu_data;
    pc_op_e                   pc_op;
    logic [XLEN-1:0]          redirect_pc;
    mem_op_e                  mem_op;
    logic [XLEN-1:0]          csr_wdata;
    logic                     csr_wvalid;
    logic [CSR_ADDRWIDTH-1:0] csr_addr;
    trap_t                    trap;
  } ex_mem_t;

endpackage

`default_nettype wire

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  core_pkg::id_ex_t   id_ex_i,
  output core_pkg::alu_res_t res_o
);

  logic [core_pkg::XLEN-1:0]        op_a;
  logic [core_pkg::XLEN-1:0]        op_b;
  logic [core_pkg::SHAMT_WIDTH-1:0] shamt;
  logic [core_pkg::XLEN-1:0]        alu_out;
  logic                             alu_lt;
  logic                             alu_ltu;
  logic [core_pkg::XLEN-1:0]        link_addr;
  logic [core_pkg::XLEN-1:0]        br_target;
  logic [core_pkg::XLEN-1:0]        jalr_sum;
  logic [core_pkg::XLEN-1:0]        redirect;
  logic                             rs_eq;
  logic                             rs_lt;
  logic                             rs_ltu;
  logic                             is_jump;
  logic                             taken;

  assign op_a  = id_ex_i.use_pc  ? id_ex_i.pc  : id_ex_i.rs1_data; // AUIPC, JAL use pc
  assign op_b  = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.rs2_data;
  assign shamt = op_b[core_pkg::SHAMT_WIDTH-1:0];

  assign alu_lt  = $signed(op_a) < $signed(op_b);
  assign alu_ltu = op_a < op_b;

  always_comb begin
    case (id_ex_i.alu_op)
      core_pkg::ALU_ADD:    alu_out = op_a + op_b;
      core_pkg::ALU_SUB:    alu_out = op_a - op_b;
      core_pkg::ALU_AND:    alu_out = op_a & op_b;
      core_pkg::ALU_OR:     alu_out = op_a | op_b;
      core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      core_pkg::ALU_SLL:    alu_out = op_a << shamt;
      core_pkg::ALU_SRL:    alu_out = op_a >> shamt;
      core_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
      core_pkg::ALU_SLT:    alu_out = {{(core_pkg::XLEN-1){1'b0}}, alu_lt};
      core_pkg::ALU_SLTU:   alu_out = {{(core_pkg::XLEN-1){1'b0}}, alu_ltu};
      core_pkg::ALU_PASS_B: alu_out = op_b;
      default:              alu_out = '0;
    endcase
  end

  // Branch compares always look at the register operands
  assign rs_eq  = id_ex_i.rs1_data == id_ex_i.rs2_data;
  assign rs_lt  = $signed(id_ex_i.rs1_data) < $signed(id_ex_i.rs2_data);
  assign rs_ltu = id_ex_i.rs1_data < id_ex_i.rs2_data;

  assign is_jump = (id_ex_i.br_op == core_pkg::BR_JAL) || (id_ex_i.br_op == core_pkg::BR_JALR);

  always_comb begin
    case (id_ex_i.br_op)
      core_pkg::BR_BEQ:  taken = rs_eq;
      core_pkg::BR_BNE:  taken = !rs_eq;
      core_pkg::BR_BLT:  taken = rs_lt;
      core_pkg::BR_BGE:  taken = !rs_lt;
      core_pkg::BR_BLTU: taken = rs_ltu;
      core_pkg::BR_BGEU: taken = !rs_ltu;
      core_pkg::BR_JAL:  taken = 1'b1;
      core_pkg::BR_JALR: taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  assign link_addr = id_ex_i.pc + 32'd4;
  assign br_target = id_ex_i.pc + id_ex_i.imm;
  assign jalr_sum  = id_ex_i.rs1_data + id_ex_i.imm;
  assign redirect  = (id_ex_i.br_op == core_pkg::BR_JALR) ?
                     {jalr_sum[core_pkg::XLEN-1:1], 1'b0} : br_target; // JALR drops bit 0

  always_comb begin
    res_o.alu_data    = is_jump ? link_addr : alu_out;
    res_o.pc_op       = taken ? core_pkg::PCOP_JUMP : core_pkg::PCOP_NONE;
    res_o.redirect_pc = redirect;
    res_o.misaligned  = taken && redirect[1]; // No compressed ISA
  end

  always_comb begin
    if (res_o.misaligned) begin
      assert (res_o.pc_op == core_pkg::PCOP_JUMP)
        else $error("ex_alu: misaligned target flagged without a taken jump");
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_csr (
  input  core_pkg::id_ex_t          id_ex_i,
  input  logic [core_pkg::XLEN-1:0] csr_rdata_i,
  output core_pkg::csr_res_t        res_o
);

  logic [core_pkg::XLEN-1:0] wdata;
  logic                      write;
  logic                      rs1_nonzero;
  logic                      read_only;

  // CSRRS/CSRRC with rs1 = x0 only read the CSR
  assign rs1_nonzero = id_ex_i.rs1_idx != '0;

  always_comb begin
    case (id_ex_i.csr_op)
      core_pkg::CSR_RW: begin
        wdata = id_ex_i.rs1_data;
        write = 1'b1;
      end
      core_pkg::CSR_RS: begin
        wdata = csr_rdata_i | id_ex_i.rs1_data; // Set bits
        write = rs1_nonzero;
      end
      core_pkg::CSR_RC: begin
        wdata = csr_rdata_i & ~id_ex_i.rs1_data; // Clear bits
        write = rs1_nonzero;
      end
      default: begin
        wdata = '0;
        write = 1'b0;
      end
    endcase
  end

  assign read_only =
    id_ex_i.csr_addr[core_pkg::CSR_ADDRWIDTH-1 -: 2] == core_pkg::CSR_RO_BITS;

  always_comb begin
    res_o.wdata   = wdata;
    res_o.wvalid  = write && !read_only;
    res_o.illegal = write && read_only;
  end

  always_comb begin
    if (res_o.wvalid) begin
      assert (id_ex_i.csr_op != core_pkg::CSR_NONE)
        else $error("ex_csr: write enable raised for a non-CSR instruction");
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               stall_i,
  input  logic               flush_i,
  input  core_pkg::id_ex_t   id_ex_i,
  input  core_pkg::alu_res_t alu_res_i,
  input  core_pkg::csr_res_t csr_res_i,
  output core_pkg::ex_mem_t  ex_mem_o
);

  core_pkg::trap_t   trap_d;
  core_pkg::ex_mem_t bubble;
  core_pkg::ex_mem_t ex_mem_d;
  core_pkg::ex_mem_t ex_mem_q;

  // Earlier stages win, then the jump target, then the CSR access
  always_comb begin
    trap_d = '0;
    if (id_ex_i.trap.valid) begin
      trap_d = id_ex_i.trap;
    end else if (alu_res_i.misaligned) begin
      trap_d.valid = 1'b1;
      trap_d.cause = core_pkg::TRAP_INST_MISALIGNED;
      trap_d.tval  = alu_res_i.redirect_pc;
    end else if (csr_res_i.illegal) begin
      trap_d.valid = 1'b1;
      trap_d.cause = core_pkg::TRAP_ILLEGAL_INST;
      trap_d.tval  = id_ex_i.inst;
    end
  end

  always_comb begin
    bubble      = '0;
    bubble.inst = core_pkg::INST_NOP;
  end

  always_comb begin
    ex_mem_d.pc          = id_ex_i.pc;
    ex_mem_d.inst        = id_ex_i.inst;
    ex_mem_d.imm         = id_ex_i.imm;
    ex_mem_d.rs1_data    = id_ex_i.rs1_data;
    ex_mem_d.rs2_data    = id_ex_i.rs2_data;
    ex_mem_d.rd_idx      = id_ex_i.rd_idx;
    ex_mem_d.alu_data    = alu_res_i.alu_data;
    ex_mem_d.pc_op       = alu_res_i.pc_op;
    ex_mem_d.redirect_pc = alu_res_i.redirect_pc;
    ex_mem_d.mem_op      = id_ex_i.mem_op;
    ex_mem_d.csr_wdata   = csr_res_i.wdata;
    ex_mem_d.csr_wvalid  = csr_res_i.wvalid;
    ex_mem_d.csr_addr    = id_ex_i.csr_addr;
    ex_mem_d.trap        = trap_d;
    if (trap_d.valid) begin // Trapping instruction has no side effects
      ex_mem_d.csr_wvalid = 1'b0;
      ex_mem_d.pc_op      = core_pkg::PCOP_NONE;
      ex_mem_d.mem_op     = core_pkg::MEMOP_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin // Flush beats stall
      ex_mem_q <= bubble;
    end else if (!stall_i) begin
      ex_mem_q <= ex_mem_d;
    end
  end

  assign ex_mem_o = ex_mem_q;

  a_flush_bubble: assert property (@(posedge clk) disable iff (reset_i)
    flush_i |=> !ex_mem_o.csr_wvalid && !ex_mem_o.trap.valid)
    else $error("ex_mem: side effect left after flush");

  a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
    stall_i && !flush_i |=> $stable(ex_mem_o))
    else $error("ex_mem: output changed during stall");

endmodule

`default_nettype wire

/* verilog/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  core_pkg::id_ex_t          id_ex_i,
  input  logic [core_pkg::XLEN-1:0] csr_rdata_i,
  output core_pkg::ex_mem_t         ex_mem_o
);

  core_pkg::alu_res_t alu_res;
  core_pkg::csr_res_t csr_res;

  ex_alu u_ex_alu (
    .id_ex_i (id_ex_i),
    .res_o   (alu_res)
  );

  ex_csr u_ex_csr (
    .id_ex_i     (id_ex_i),
    .csr_rdata_i (csr_rdata_i),
    .res_o       (csr_res)
  );

  // Both units see the same instruction in parallel
  ex_mem u_ex_mem (
    .clk       (clk),
    .reset_i   (reset_i),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .id_ex_i   (id_ex_i),
    .alu_res_i (alu_res),
    .csr_res_i (csr_res),
    .ex_mem_o  (ex_mem_o)
  );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // 100 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic              clk_i,
  input  logic              check_i,
  input  int                idx_i,
  input  core_pkg::ex_mem_t exp_i,
  input  core_pkg::ex_mem_t act_i,
  output int                pass_cnt_o,
  output int                fail_cnt_o
);

  int   pass_cnt = 0;
  int   fail_cnt = 0;
  logic mismatch;

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
      mismatch = 1'b1;
    end
  endtask

  // Output is stable here, half a cycle after the capturing edge
  always @(negedge clk_i) begin
    if (check_i) begin
      mismatch = 1'b0;
      compare_field("pc", exp_i.pc, act_i.pc);
      compare_field("inst", exp_i.inst, act_i.inst);
      compare_field("imm", exp_i.imm, act_i.imm);
      compare_field("rs1_data", exp_i.rs1_data, act_i.rs1_data);
      compare_field("rs2_data", exp_i.rs2_data, act_i.rs2_data);
      compare_field("rd_idx", 32'(exp_i.rd_idx), 32'(act_i.rd_idx));
      compare_field("alu_data", exp_i.alu_data, act_i.alu_data);
      compare_field("pc_op", 32'(exp_i.pc_op), 32'(act_i.pc_op));
      compare_field("redirect_pc", exp_i.redirect_pc, act_i.redirect_pc);
      compare_field("mem_op", 32'(exp_i.mem_op), 32'(act_i.mem_op));
      compare_field("csr_wdata", exp_i.csr_wdata, act_i.csr_wdata);
      compare_field("csr_wvalid", 32'(exp_i.csr_wvalid), 32'(act_i.csr_wvalid));
      compare_field("csr_addr", 32'(exp_i.csr_addr), 32'(act_i.csr_addr));
      compare_field("trap.valid", 32'(exp_i.trap.valid), 32'(act_i.trap.valid));
      compare_field("trap.cause", 32'(exp_i.trap.cause), 32'(act_i.trap.cause));
      compare_field("trap.tval", exp_i.trap.tval, act_i.trap.tval);
      if (mismatch) begin
        fail_cnt = fail_cnt + 1;
        $display("test %0d: mismatch", idx_i);
      end else begin
        pass_cnt = pass_cnt + 1;
        $display("test %0d: ok", idx_i);
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

  logic                      clk;
  logic                      reset_i;
  logic                      stall_i;
  logic                      flush_i;
  core_pkg::id_ex_t          id_ex_i;
  logic [core_pkg::XLEN-1:0] csr_rdata_i;
  core_pkg::ex_mem_t         ex_mem_o;

  core_pkg::id_ex_t          tbl_id[$];
  core_pkg::ex_mem_t         tbl_exp[$];
  logic [core_pkg::XLEN-1:0] tbl_rdata[$];
  logic                      tbl_stall[$];
  logic                      tbl_flush[$];
  core_pkg::ex_mem_t         bubble;
  core_pkg::ex_mem_t         last_exp;

  logic              check_en;
  int                check_idx;
  core_pkg::ex_mem_t check_exp;
  int                pass_cnt;
  int                fail_cnt;
  int                cycle_cnt = 0;
  int                cycle_limit = 0;

  tb_clkgen u_clkgen (.clk_o(clk), .reset_o(reset_i));

  ex_top DUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .id_ex_i     (id_ex_i),
    .csr_rdata_i (csr_rdata_i),
    .ex_mem_o    (ex_mem_o)
  );

  tb_checker u_checker (
    .clk_i      (clk),
    .check_i    (check_en),
    .idx_i      (check_idx),
    .exp_i      (check_exp),
    .act_i      (ex_mem_o),
    .pass_cnt_o (pass_cnt),
    .fail_cnt_o (fail_cnt)
  );

  function automatic core_pkg::id_ex_t make_id(
    input logic [31:0] pc, input logic [31:0] inst, input logic [31:0] imm,
    input logic [31:0] rs1, input logic [31:0] rs2, input core_pkg::alu_op_e alu_op,
    input logic use_imm, input logic use_pc, input core_pkg::br_op_e br_op);
    core_pkg::id_ex_t id;
    id          = '0;
    id.pc       = pc;
    id.inst     = inst;
    id.imm      = imm;
    id.rs1_data = rs1;
    id.rs2_data = rs2;
    id.rs1_idx  = 5'd1;
    id.rd_idx   = inst[11:7];
    id.alu_op   = alu_op;
    id.use_imm  = use_imm;
    id.use_pc   = use_pc;
    id.br_op    = br_op;
    return id;
  endfunction

  // Pass-through fields plus ALU result, target is pc+imm unless JALR
  function automatic core_pkg::ex_mem_t expect_alu(input core_pkg::id_ex_t id,
    input logic [31:0] alu_data, input core_pkg::pc_op_e pc_op);
    core_pkg::ex_mem_t e;
    e             = '0;
    e.pc          = id.pc;
    e.inst        = id.inst;
    e.imm         = id.imm;
    e.rs1_data    = id.rs1_data;
    e.rs2_data    = id.rs2_data;
    e.rd_idx      = id.rd_idx;
    e.mem_op      = id.mem_op;
    e.csr_addr    = id.csr_addr;
    e.alu_data    = alu_data;
    e.pc_op       = pc_op;
    e.redirect_pc = id.pc + id.imm;
    return e;
  endfunction

  function automatic core_pkg::ex_mem_t with_trap(input core_pkg::ex_mem_t e_in,
    input core_pkg::trap_cause_e cause, input logic [31:0] tval);
    core_pkg::ex_mem_t e;
    e            = e_in;
    e.trap.valid = 1'b1;
    e.trap.cause = cause;
    e.trap.tval  = tval;
    e.pc_op      = core_pkg::PCOP_NONE; // No side effects on a trap
    e.mem_op     = core_pkg::MEMOP_NONE;
    e.csr_wvalid = 1'b0;
    return e;
  endfunction

  task automatic add_entry(input logic stall, input logic flush, input core_pkg::id_ex_t id,
                           input logic [31:0] rdata, input core_pkg::ex_mem_t exp_in);
    core_pkg::ex_mem_t e;
    e = exp_in;
    if (flush) e = bubble;
    else if (stall) e = last_exp;
    last_exp = e;
    tbl_stall.push_back(stall);
    tbl_flush.push_back(flush);
    tbl_id.push_back(id);
    tbl_rdata.push_back(rdata);
    tbl_exp.push_back(e);
  endtask

  task automatic build_table();
    core_pkg::id_ex_t  id;
    core_pkg::ex_mem_t e;
    logic [31:0]       a;
    logic [31:0]       b;
    a = $urandom();
    b = $urandom();
    id = make_id(32'h100, 32'h00b5_0533, 0, a, b, core_pkg::ALU_ADD, 0, 0, core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, a + b, core_pkg::PCOP_NONE));
    id = make_id(32'h104, 32'h40b5_0533, 0, a, b, core_pkg::ALU_SUB, 0, 0, core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, a - b, core_pkg::PCOP_NONE));
    id = make_id(32'h108, 32'h00b5_4533, 0, a, b, core_pkg::ALU_XOR, 0, 0, core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, a ^ b, core_pkg::PCOP_NONE));
    id = make_id(32'h10c, 32'h00b5_3533, 0, a, b, core_pkg::ALU_SLTU, 0, 0, core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'(a < b), core_pkg::PCOP_NONE));
    id = make_id(32'h110, 32'hff05_0513, 32'hffff_fff0, 32'h10, 32'h7, core_pkg::ALU_ADD, 1, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h0, core_pkg::PCOP_NONE));
    id = make_id(32'h114, 32'h00b5_6533, 0, 32'hf0f0_0000, 32'h0000_0f0f, core_pkg::ALU_OR, 0, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'hf0f0_0f0f, core_pkg::PCOP_NONE));
    id = make_id(32'h118, 32'h00b5_1533, 0, 32'h1, 32'h25, core_pkg::ALU_SLL, 0, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h20, core_pkg::PCOP_NONE));
    id = make_id(32'h11c, 32'h0045_5513, 32'h4, 32'h8000_0000, 0, core_pkg::ALU_SRL, 1, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h0800_0000, core_pkg::PCOP_NONE));
    id = make_id(32'h120, 32'h4045_5513, 32'h4, 32'h8000_0000, 0, core_pkg::ALU_SRA, 1, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'hf800_0000, core_pkg::PCOP_NONE));
    id = make_id(32'h124, 32'h00b5_2533, 0, 32'hffff_ffff, 32'h1, core_pkg::ALU_SLT, 0, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h1, core_pkg::PCOP_NONE));
    id = make_id(32'h128, 32'h00b5_3533, 0, 32'hffff_ffff, 32'h1, core_pkg::ALU_SLTU, 0, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h0, core_pkg::PCOP_NONE));
    id = make_id(32'h200, 32'h0000_1517, 32'h1000, 0, 0, core_pkg::ALU_ADD, 1, 1,
                 core_pkg::BR_NONE); // AUIPC
    add_entry(0, 0, id, 0, expect_alu(id, 32'h1200, core_pkg::PCOP_NONE));
    id = make_id(32'h204, 32'habcd_e537, 32'habcd_e000, 0, 0, core_pkg::ALU_PASS_B, 1, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'habcd_e000, core_pkg::PCOP_NONE));
    id = make_id(32'h300, 32'h04b5_0063, 32'h40, 5, 5, core_pkg::ALU_SUB, 0, 0, core_pkg::BR_BEQ);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h0, core_pkg::PCOP_JUMP));
    id = make_id(32'h304, 32'h04b5_1063, 32'h40, 5, 5, core_pkg::ALU_SUB, 0, 0, core_pkg::BR_BNE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h0, core_pkg::PCOP_NONE));
    id = make_id(32'h308, 32'h04b5_4063, 32'h40, 32'hffff_fffe, 1, core_pkg::ALU_SUB, 0, 0,
                 core_pkg::BR_BLT);
    add_entry(0, 0, id, 0, expect_alu(id, 32'hffff_fffd, core_pkg::PCOP_JUMP));
    id = make_id(32'h30c, 32'h04b5_6063, 32'h40, 32'hffff_fffe, 1, core_pkg::ALU_SUB, 0, 0,
                 core_pkg::BR_BLTU);
    add_entry(0, 0, id, 0, expect_alu(id, 32'hffff_fffd, core_pkg::PCOP_NONE));
    id = make_id(32'h400, 32'h0200_00ef, 32'h20, 0, 0, core_pkg::ALU_ADD, 1, 1, core_pkg::BR_JAL);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h404, core_pkg::PCOP_JUMP));
    id = make_id(32'h410, 32'h0105_00e7, 32'h10, 32'h1001, 0, core_pkg::ALU_ADD, 1, 0,
                 core_pkg::BR_JALR);
    e = expect_alu(id, 32'h414, core_pkg::PCOP_JUMP);
    e.redirect_pc = 32'h1010; // 0x1011 with bit 0 cleared
    add_entry(0, 0, id, 0, e);
    id = make_id(32'h500, 32'h3005_1573, 0, 32'h55, 0, core_pkg::ALU_ADD, 0, 0, core_pkg::BR_NONE);
    id.csr_op   = core_pkg::CSR_RW;
    id.csr_addr = 12'h300;
    e = expect_alu(id, 32'h55, core_pkg::PCOP_NONE);
    e.csr_wdata  = 32'h55;
    e.csr_wvalid = 1'b1;
    add_entry(0, 0, id, 32'hf0, e);
    id.inst = 32'h3005_2573;
    id.rs1_data = 32'h0f;
    id.csr_op = core_pkg::CSR_RS;
    e = expect_alu(id, 32'h0f, core_pkg::PCOP_NONE);
    e.csr_wdata  = 32'hff;
    e.csr_wvalid = 1'b1;
    add_entry(0, 0, id, 32'hf0, e);
    id.inst = 32'h3005_3573;
    id.rs1_data = 32'h30;
    id.csr_op = core_pkg::CSR_RC;
    e = expect_alu(id, 32'h30, core_pkg::PCOP_NONE);
    e.csr_wdata  = 32'hc0;
    e.csr_wvalid = 1'b1;
    add_entry(0, 0, id, 32'hf0, e);
    id.inst = 32'h3000_2573; // csrr, rs1 is x0
    id.rs1_data = 0;
    id.rs1_idx = 0;
    id.csr_op = core_pkg::CSR_RS;
    e = expect_alu(id, 32'h0, core_pkg::PCOP_NONE);
    e.csr_wdata = 32'hf0;
    add_entry(0, 0, id, 32'hf0, e);
    id = make_id(32'h600, 32'h0020_00ef, 32'h2, 0, 0, core_pkg::ALU_ADD, 1, 1, core_pkg::BR_JAL);
    id.mem_op     = core_pkg::MEMOP_LW;
    id.trap.valid = 1'b1;
    id.trap.cause = core_pkg::TRAP_ILLEGAL_INST;
    id.trap.tval  = 32'hdead_beef;
    id.csr_op     = core_pkg::CSR_RW; // Writable CSR, write must be dropped
    id.csr_addr   = 12'h340;
    e = expect_alu(id, 32'h604, core_pkg::PCOP_JUMP);
    add_entry(0, 0, id, 0, with_trap(e, core_pkg::TRAP_ILLEGAL_INST, 32'hdead_beef));
    id = make_id(32'h700, 32'h0020_00ef, 32'h2, 0, 0, core_pkg::ALU_ADD, 1, 1, core_pkg::BR_JAL);
    e = expect_alu(id, 32'h704, core_pkg::PCOP_JUMP);
    add_entry(0, 0, id, 0, with_trap(e, core_pkg::TRAP_INST_MISALIGNED, 32'h702));
    id = make_id(32'h704, 32'hc005_1573, 0, 32'h55, 0, core_pkg::ALU_ADD, 0, 0, core_pkg::BR_NONE);
    id.csr_op   = core_pkg::CSR_RW;
    id.csr_addr = 12'hc00; // cycle, read-only
    e = expect_alu(id, 32'h55, core_pkg::PCOP_NONE);
    e.csr_wdata = 32'h55;
    add_entry(0, 0, id, 0, with_trap(e, core_pkg::TRAP_ILLEGAL_INST, id.inst));
    id = make_id(32'h800, 32'h0085_2503, 32'h8, 32'h1000, 0, core_pkg::ALU_ADD, 1, 0,
                 core_pkg::BR_NONE);
    id.mem_op = core_pkg::MEMOP_LW;
    add_entry(0, 0, id, 0, expect_alu(id, 32'h1008, core_pkg::PCOP_NONE));
    for (int k = 0; k < 3; k++) begin
      id = make_id(32'h900 + 32'(4 * k), $urandom(), 0, $urandom(), $urandom(),
                   core_pkg::ALU_ADD, 0, 0, core_pkg::BR_NONE);
      add_entry(1, 0, id, 0, '0); // Held
    end
    add_entry(1, 1, id, 0, '0);
    id = make_id(32'ha00, 32'h00b5_0533, 0, 32'h3, 32'h4, core_pkg::ALU_ADD, 0, 0,
                 core_pkg::BR_NONE);
    add_entry(0, 0, id, 0, expect_alu(id, 32'h7, core_pkg::PCOP_NONE));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h7adb_397c));
    stall_i     = 1'b1; // Holds the reset bubble over the first edge after reset
    flush_i     = 1'b0;
    id_ex_i     = '0;
    csr_rdata_i = '0;
    check_en    = 1'b0;
    check_idx   = 0;
    check_exp   = '0;
    bubble      = '0;
    bubble.inst = core_pkg::INST_NOP;
    last_exp    = bubble;
    build_table();
    cycle_limit = 10 * tbl_id.size() + 50;
    @(negedge reset_i);
    for (int i = 0; i <= tbl_id.size(); i++) begin
      @(posedge clk);
      #1;
      check_en  = 1'b1;
      check_idx = i;
      check_exp = (i == 0) ? bubble : tbl_exp[i-1];
      if (i < tbl_id.size()) begin
        stall_i     = tbl_stall[i];
        flush_i     = tbl_flush[i];
        id_ex_i     = tbl_id[i];
        csr_rdata_i = tbl_rdata[i];
      end else begin
        stall_i = 1'b0;
        flush_i = 1'b1;
      end
    end
    @(negedge clk);
    #1;
    check_en = 1'b0;
    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == tbl_id.size() + 1) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/core_pkg.sv
verilog/ex_alu.sv
verilog/ex_csr.sv
verilog/ex_mem.sv
verilog/ex_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_ex_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_ex_top -o Vtb_ex_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ex_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No result found in $LOG"
  exit 1
fi
exit 0
